/* src/memtest_defs.svh */
`ifndef MEMTEST_DEFS_SVH
`define MEMTEST_DEFS_SVH

//////////////////////////////
// memory geometry
`define MT_ADDR_W      10    // word address, 1024 words
`define MT_DATA_W      32
`define MT_MASK_W      4     // one bit per byte
`define MT_BL_W        6     // burst length minus one

// port queues
`define MT_FIFO_DEPTH  16

//////////////////////////////
// frame region for scanout
`define MT_SCAN_BURST  8     // words per read command
`define MT_FRAME_BASE  512   // word address
`define MT_FRAME_WORDS 64    // multiple of the scan burst

`endif

/* src/memtest_pkg.sv */
`include "memtest_defs.svh"

package memtest_pkg;

  //////////////////////////////
  // command queue payload

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e               op;
    logic [`MT_BL_W-1:0]   bl;    // words minus one
    logic [`MT_ADDR_W-1:0] addr;  // first word of the burst
  } mem_cmd_t;

  //////////////////////////////
  // data queue payloads

  // mask bit set keeps the stored byte
  typedef struct packed {
    logic [`MT_DATA_W-1:0] data;
    logic [`MT_MASK_W-1:0] mask;
  } mem_wr_t;

  typedef struct packed {
    logic [`MT_DATA_W-1:0] data;
  } mem_rd_t;

endpackage

/* src/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if import memtest_pkg::*; ();

  // command queue
  logic     cmd_en;
  mem_cmd_t cmd;
  logic     cmd_full;

  // write data queue, filled before its command
  logic     wr_en;
  mem_wr_t  wr;
  logic     wr_full;

  // read data queue, rd shows the head word
  logic     rd_en;
  mem_rd_t  rd;
  logic     rd_empty;

  // client side of the port
  modport client (
    output cmd_en, cmd, wr_en, wr, rd_en,
    input  cmd_full, wr_full, rd, rd_empty
  );

  // controller side
  modport ctrl (
    input  cmd_en, cmd, wr_en, wr, rd_en,
    output cmd_full, wr_full, rd, rd_empty
  );

endinterface

/* src/port_fifo.sv */
`timescale 1ns/1ps
`include "memtest_defs.svh"

module port_fifo import memtest_pkg::*; #(
  parameter type T     = mem_rd_t,
  parameter int  DEPTH = `MT_FIFO_DEPTH  // power of two
) (
  input  logic sys_clk,
  input  logic reset,
  input  logic push,
  input  T     din,
  input  logic pop,
  output T     dout,
  output logic full,
  output logic empty
);

  localparam int AW = $clog2(DEPTH);

  T             store [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;   // one extra bit for full

  wire do_push = push && !full;
  wire do_pop  = pop && !empty;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                            // both or neither
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (do_push) store[wr_ptr] <= din;
  end

  assign dout  = store[rd_ptr];  // head word, valid while not empty
  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);

  // clients must respect the flags
  a_no_overflow: assert property (@(posedge sys_clk) disable iff (reset) push |-> !full);
  a_no_underflow: assert property (@(posedge sys_clk) disable iff (reset) pop |-> !empty);

endmodule

/* src/mem_port_ctrl.sv */
`timescale 1ns/1ps
`include "memtest_defs.svh"

module mem_port_ctrl import memtest_pkg::*; (
  input  logic     sys_clk,
  input  logic     reset,
  mem_port_if.ctrl p0,   // host port
  mem_port_if.ctrl p1    // scanout port
);

  mem_cmd_t   cmd_head [2];
  mem_wr_t    wq_head [2];
  logic [1:0] cmd_empty;
  logic [1:0] cmd_pop;
  logic [1:0] wq_empty;
  logic [1:0] wq_pop;
  logic [1:0] rq_full;
  logic [1:0] rq_push;
  mem_rd_t    rd_hold;   // word on its way into a read queue

  logic [`MT_DATA_W-1:0] mem [2**`MT_ADDR_W];  // stands in for the dram

  //////////////////////////////
  // per port queues

  port_fifo #(.T(mem_cmd_t), .DEPTH(`MT_FIFO_DEPTH)) p0_cmd_q (
    .sys_clk, .reset, .push(p0.cmd_en), .din(p0.cmd), .pop(cmd_pop[0]),
    .dout(cmd_head[0]), .full(p0.cmd_full), .empty(cmd_empty[0]));
  port_fifo #(.T(mem_wr_t), .DEPTH(`MT_FIFO_DEPTH)) p0_wr_q (
    .sys_clk, .reset, .push(p0.wr_en), .din(p0.wr), .pop(wq_pop[0]),
    .dout(wq_head[0]), .full(p0.wr_full), .empty(wq_empty[0]));
  port_fifo #(.T(mem_rd_t), .DEPTH(`MT_FIFO_DEPTH)) p0_rd_q (
    .sys_clk, .reset, .push(rq_push[0]), .din(rd_hold), .pop(p0.rd_en),
    .dout(p0.rd), .full(rq_full[0]), .empty(p0.rd_empty));

  port_fifo #(.T(mem_cmd_t), .DEPTH(`MT_FIFO_DEPTH)) p1_cmd_q (
    .sys_clk, .reset, .push(p1.cmd_en), .din(p1.cmd), .pop(cmd_pop[1]),
    .dout(cmd_head[1]), .full(p1.cmd_full), .empty(cmd_empty[1]));
  port_fifo #(.T(mem_wr_t), .DEPTH(`MT_FIFO_DEPTH)) p1_wr_q (
    .sys_clk, .reset, .push(p1.wr_en), .din(p1.wr), .pop(wq_pop[1]),
    .dout(wq_head[1]), .full(p1.wr_full), .empty(wq_empty[1]));
  port_fifo #(.T(mem_rd_t), .DEPTH(`MT_FIFO_DEPTH)) p1_rd_q (
    .sys_clk, .reset, .push(rq_push[1]), .din(rd_hold), .pop(p1.rd_en),
    .dout(p1.rd), .full(rq_full[1]), .empty(p1.rd_empty));

  //////////////////////////////
  // round robin arbiter

  logic                  busy;
  logic                  cur_port;  // owner of the running burst and last grant
  mem_op_e               cur_op;
  logic [`MT_ADDR_W-1:0] cur_addr;
  logic [`MT_BL_W-1:0]   remain;    // words left minus one
  logic                  rd_hold_valid;
  logic                  rd_hold_port;
  logic                  gnt_valid;
  logic                  gnt_port;

  always_comb begin
    gnt_valid = 1'b0;
    gnt_port  = 1'b0;
    if (!busy) begin
      if (!cmd_empty[~cur_port]) begin  // other port first
        gnt_valid = 1'b1;
        gnt_port  = ~cur_port;
      end else if (!cmd_empty[cur_port]) begin
        gnt_valid = 1'b1;
        gnt_port  = cur_port;
      end
    end
  end

  assign cmd_pop = gnt_valid ? (2'b01 << gnt_port) : 2'b00;

  //////////////////////////////
  // burst engine

  // hold stage frees up when empty or draining this cycle
  wire hold_free = !rd_hold_valid || !rq_full[rd_hold_port];
  wire step_wr   = busy && (cur_op == OP_WRITE);
  wire step_rd   = busy && (cur_op == OP_READ) && hold_free;  // stalls on full
  wire step      = step_wr || step_rd;

  assign wq_pop  = step_wr ? (2'b01 << cur_port) : 2'b00;
  assign rq_push = (rd_hold_valid && !rq_full[rd_hold_port]) ? (2'b01 << rd_hold_port) : 2'b00;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      busy          <= 1'b0;
      cur_port      <= 1'b0;
      rd_hold_valid <= 1'b0;
    end else begin
      if (gnt_valid) begin
        busy     <= 1'b1;
        cur_port <= gnt_port;
      end else if (step && remain == '0) begin
        busy <= 1'b0;   // last word of the burst
      end
      if (step_rd) begin
        rd_hold_valid <= 1'b1;
      end else if (|rq_push) begin
        rd_hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (gnt_valid) begin
      cur_op   <= cmd_head[gnt_port].op;
      cur_addr <= cmd_head[gnt_port].addr;
      remain   <= cmd_head[gnt_port].bl;
    end else if (step) begin
      cur_addr <= cur_addr + 1'b1;
      remain   <= remain - 1'b1;
    end
    if (step_rd) begin
      rd_hold.data <= mem[cur_addr];
      rd_hold_port <= cur_port;
    end
    if (step_wr) begin
      for (int b = 0; b < `MT_MASK_W; b++) begin
        if (!wq_head[cur_port].mask[b]) begin
          mem[cur_addr][8*b +: 8] <= wq_head[cur_port].data[8*b +: 8];
        end
      end
    end
  end

  // data must be queued before its command reaches the engine
  a_wr_data_ready: assert property (@(posedge sys_clk) disable iff (reset)
    step_wr |-> !wq_empty[cur_port]);

endmodule

/* src/wb_port_bridge.sv */
`timescale 1ns/1ps
`include "memtest_defs.svh"

module wb_port_bridge import memtest_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`MT_ADDR_W-1:0] wb_adr,
  input  logic [`MT_MASK_W-1:0] wb_sel,
  input  logic [`MT_DATA_W-1:0] wb_dat_w,
  output logic [`MT_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack,
  mem_port_if.client            port
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT_RD,   // read command queued, waiting on data
    S_ACK        // ack cycle
  } state_e;

  state_e state;

  wire req = wb_cyc && wb_stb;

  //////////////////////////////
  // control fsm

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state       <= S_IDLE;
      wb_ack      <= 1'b0;
      port.cmd_en <= 1'b0;
      port.wr_en  <= 1'b0;
      port.rd_en  <= 1'b0;
    end else begin
      port.cmd_en <= 1'b0;   // single cycle pulses
      port.wr_en  <= 1'b0;
      port.rd_en  <= 1'b0;
      wb_ack      <= 1'b0;
      case (state)
        S_IDLE: begin
          if (req && wb_we && !port.cmd_full && !port.wr_full) begin
            port.wr_en  <= 1'b1;  // data and command together
            port.cmd_en <= 1'b1;
            wb_ack      <= 1'b1;
            state       <= S_ACK;
          end else if (req && !wb_we && !port.cmd_full) begin
            port.cmd_en <= 1'b1;
            state       <= S_WAIT_RD;
          end
        end
        S_WAIT_RD: begin
          if (!port.rd_empty) begin
            port.rd_en <= 1'b1;   // pop lands in the ack cycle
            wb_ack     <= 1'b1;
            state      <= S_ACK;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload capture, master holds the bus stable
  always_ff @(posedge sys_clk) begin
    if (state == S_IDLE && req) begin
      port.cmd <= '{op: (wb_we ? OP_WRITE : OP_READ), bl: '0, addr: wb_adr};
      port.wr  <= '{data: wb_dat_w, mask: ~wb_sel};  // sel bit set means write
    end
    if (state == S_WAIT_RD && !port.rd_empty) wb_dat_r <= port.rd.data;
  end

  // classic protocol on the host side
  a_stb_held: assert property (@(posedge sys_clk) disable iff (reset)
    (req && !wb_ack) |=> wb_stb);
  a_ack_pulse: assert property (@(posedge sys_clk) disable iff (reset)
    wb_ack |=> !wb_ack);

endmodule

/* src/frame_scan_reader.sv */
`timescale 1ns/1ps
`include "memtest_defs.svh"

module frame_scan_reader import memtest_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  logic                  scan_en,
  output logic                  pix_valid,
  output logic                  pix_sof,
  output logic [`MT_DATA_W-1:0] pix_data,
  mem_port_if.client            port
);

  localparam int OUT_W = $clog2(`MT_FIFO_DEPTH) + 1;
  localparam int OFF_W = $clog2(`MT_FRAME_WORDS);

  localparam logic [OUT_W-1:0]      BURST_N    = OUT_W'(`MT_SCAN_BURST);
  localparam logic [OUT_W-1:0]      OUT_MAX    = OUT_W'(`MT_FIFO_DEPTH - `MT_SCAN_BURST);
  localparam logic [OFF_W-1:0]      LAST_OFF   = OFF_W'(`MT_FRAME_WORDS - 1);
  localparam logic [OFF_W-1:0]      LAST_BURST = OFF_W'(`MT_FRAME_WORDS - `MT_SCAN_BURST);
  localparam logic [OFF_W-1:0]      STEP       = OFF_W'(`MT_SCAN_BURST);
  localparam logic [`MT_BL_W-1:0]   SCAN_BL    = `MT_BL_W'(`MT_SCAN_BURST - 1);
  localparam logic [`MT_ADDR_W-1:0] FRAME_BASE = `MT_ADDR_W'(`MT_FRAME_BASE);

  logic             active;       // scanning, cleared on scan_en low
  logic [OUT_W-1:0] outstanding;  // requested but not yet popped
  logic [OFF_W-1:0] issue_off;    // frame offset of the next command
  logic [OFF_W-1:0] pix_off;      // frame offset of the next popped word

  wire pop   = !port.rd_empty;
  // at most every other cycle so cmd_full is never stale
  wire issue = active && scan_en && !port.cmd_en && !port.cmd_full
               && (outstanding <= OUT_MAX);

  assign port.rd_en = pop;
  assign port.wr_en = 1'b0;   // read-only client
  assign port.wr    = '0;

  //////////////////////////////
  // issue and pop tracking

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      active      <= 1'b0;
      outstanding <= '0;
      issue_off   <= '0;
      pix_off     <= '0;
      port.cmd_en <= 1'b0;
      pix_valid   <= 1'b0;
      pix_sof     <= 1'b0;
    end else begin
      port.cmd_en <= issue;
      pix_valid   <= pop;
      pix_sof     <= pop && (pix_off == '0);
      case ({issue, pop})
        2'b10:   outstanding <= outstanding + BURST_N;
        2'b01:   outstanding <= outstanding - 1'b1;
        2'b11:   outstanding <= outstanding + BURST_N - 1'b1;
        default: ;
      endcase
      if (issue) issue_off <= (issue_off == LAST_BURST) ? '0 : issue_off + STEP;
      if (pop) pix_off <= (pix_off == LAST_OFF) ? '0 : pix_off + 1'b1;
      if (!scan_en) begin
        active <= 1'b0;          // stop issuing, keep draining
      end else if (!active && outstanding == '0) begin
        active    <= 1'b1;       // drained, restart at frame base
        issue_off <= '0;
        pix_off   <= '0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (issue) port.cmd <= '{op: OP_READ, bl: SCAN_BL, addr: FRAME_BASE + `MT_ADDR_W'(issue_off)};
    if (pop) pix_data <= port.rd.data;  // one cycle after the pop
  end

endmodule

/* src/memtest_top.sv */
`timescale 1ns/1ps
`include "memtest_defs.svh"

module memtest_top (
  input  logic                  sys_clk,
  input  logic                  reset,
  // wishbone host
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`MT_ADDR_W-1:0] wb_adr,
  input  logic [`MT_MASK_W-1:0] wb_sel,
  input  logic [`MT_DATA_W-1:0] wb_dat_w,
  output logic [`MT_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack,
  // scanout
  input  logic                  scan_en,
  output logic                  pix_valid,
  output logic                  pix_sof,
  output logic [`MT_DATA_W-1:0] pix_data
);

  mem_port_if p0_if ();   // host port
  mem_port_if p1_if ();   // scanout port

  wb_port_bridge wb_port_bridge_i (
    .sys_clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_w,
    .wb_dat_r, .wb_ack, .port(p0_if));

  frame_scan_reader frame_scan_reader_i (
    .sys_clk, .reset, .scan_en, .pix_valid, .pix_sof, .pix_data, .port(p1_if));

  mem_port_ctrl mem_port_ctrl_i (
    .sys_clk, .reset, .p0(p0_if), .p1(p1_if));

endmodule

/* test/memtest_checker.sv */
`timescale 1ns/1ps
`include "memtest_defs.svh"

module memtest_checker (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`MT_ADDR_W-1:0] wb_adr,
  input  logic [`MT_MASK_W-1:0] wb_sel,
  input  logic [`MT_DATA_W-1:0] wb_dat_w,
  input  logic [`MT_DATA_W-1:0] wb_dat_r,
  input  logic                  wb_ack,
  input  logic                  scan_en,
  input  logic                  pix_valid,
  input  logic                  pix_sof,
  input  logic [`MT_DATA_W-1:0] pix_data,
  input  int                    test_num,
  output int                    errors,
  output int                    pix_count   // pixels seen so far
);

  logic [`MT_DATA_W-1:0] model [2**`MT_ADDR_W];  // reference copy of the array
  bit                    known [2**`MT_ADDR_W];  // word written at least once
  int                    err_n = 0;
  int                    pix_off = 0;            // expected frame offset of next pixel
  logic                  rst_d = 1'b0;
  logic                  scan_d = 1'b0;

  assign errors = err_n;

  function automatic string test_name(int n);
    case (n)
      1: return "write_read";
      2: return "byte_select";
      3: return "frame_scan";
      4: return "scan_traffic";
      5: return "scan_restart";
      default: return "reset";
    endcase
  endfunction

  //////////////////////////////
  // compare helpers

  task automatic check_read();
    if (!known[wb_adr]) begin
      err_n++;
      $display("ERROR %s: bus read of address %0d, which was never written",
               test_name(test_num), wb_adr);
    end else if (wb_dat_r !== model[wb_adr]) begin
      err_n++;
      $display("CHECK FAILED %s: read adr %0d expected %h actual %h",
               test_name(test_num), wb_adr, model[wb_adr], wb_dat_r);
    end
  endtask

  task automatic check_pixel(int off);
    int a;
    a = `MT_FRAME_BASE + off;
    if (!known[a]) begin
      err_n++;
      $display("ERROR %s: pixel from frame word %0d, which was never written",
               test_name(test_num), a);
    end else if (pix_data !== model[a]) begin
      err_n++;
      $display("CHECK FAILED %s: pixel offset %0d expected %h actual %h",
               test_name(test_num), off, model[a], pix_data);
    end
    if (pix_sof !== (off == 0)) begin
      err_n++;
      $display("CHECK FAILED %s: pix_sof at offset %0d expected %0d actual %0d",
               test_name(test_num), off, (off == 0), pix_sof);
    end
  endtask

  //////////////////////////////
  // monitor sampled at the rising edge

  always @(posedge sys_clk) begin
    rst_d  <= reset;
    scan_d <= scan_en;
    if (reset) begin
      pix_off <= 0;
      if (rst_d && (wb_ack || pix_valid)) begin  // flops cleared by now
        err_n++;
        $display("ERROR %s: wb_ack or pix_valid high during reset", test_name(test_num));
      end
    end else begin
      if (wb_ack && wb_cyc && wb_stb && wb_we) begin
        for (int b = 0; b < `MT_MASK_W; b++) begin
          if (wb_sel[b]) model[wb_adr][8*b +: 8] = wb_dat_w[8*b +: 8];  // selected bytes only
        end
        known[wb_adr] = 1'b1;
      end
      if (wb_ack && wb_cyc && wb_stb && !wb_we) check_read();
      if (pix_sof && !pix_valid) begin
        err_n++;
        $display("ERROR %s: pix_sof high without pix_valid", test_name(test_num));
      end
      if (pix_valid) begin
        check_pixel(pix_off);
        pix_count <= pix_count + 1;
        pix_off   <= (pix_off == `MT_FRAME_WORDS - 1) ? 0 : pix_off + 1;
      end else if (scan_en && !scan_d) begin
        pix_off <= 0;   // scan restarts at the frame base
      end
    end
  end

  initial pix_count = 0;

endmodule

/* test/tb_memtest.sv */
`timescale 1ns/1ps
`include "memtest_defs.svh"

module tb_memtest;

  localparam int N_WORDS   = 200;  // full word writes and as many reads
  localparam int N_BYTE    = 100;  // partial write plus read back
  localparam int N_MIXED   = 100;  // bus ops while scanning
  localparam int FRAMES    = 3;
  localparam int TOTAL_OPS = 2*N_WORDS + 2*N_BYTE + `MT_FRAME_WORDS + 1 + N_MIXED
                             + 8*`MT_FRAME_WORDS;
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 200;

  logic                  sys_clk;
  logic                  reset;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`MT_ADDR_W-1:0] wb_adr;
  logic [`MT_MASK_W-1:0] wb_sel;
  logic [`MT_DATA_W-1:0] wb_dat_w;
  logic [`MT_DATA_W-1:0] wb_dat_r;
  logic                  wb_ack;
  logic                  scan_en;
  logic                  pix_valid;
  logic                  pix_sof;
  logic [`MT_DATA_W-1:0] pix_data;
  int                    test_num;
  int                    errors;
  int                    pix_count;

  logic [`MT_ADDR_W-1:0] wr_list [$];      // host addresses holding known data
  bit                    written [`MT_FRAME_BASE];

  always #5 sys_clk = ~sys_clk;

  memtest_top memtest_top_i (.*);

  memtest_checker checker_i (.*);

  //////////////////////////////
  // stimulus helpers

  task automatic apply_reset();
    @(posedge sys_clk);
    reset <= 1'b1;
    repeat (4) @(posedge sys_clk);
    reset <= 1'b0;
  endtask

  // one classic cycle held until ack
  task automatic bus_cycle(input logic we, input logic [`MT_ADDR_W-1:0] adr,
                           input logic [`MT_MASK_W-1:0] sel,
                           input logic [`MT_DATA_W-1:0] dat);
    @(posedge sys_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_sel   <= sel;
    wb_dat_w <= dat;
    do begin
      @(posedge sys_clk);
    end while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic write_host(input logic [`MT_ADDR_W-1:0] adr);
    bus_cycle(1'b1, adr, 4'hf, $urandom());
    if (!written[adr]) begin
      written[adr] = 1'b1;
      wr_list.push_back(adr);
    end
  endtask

  function automatic logic [`MT_ADDR_W-1:0] pick_written();
    return wr_list[$urandom_range(wr_list.size() - 1, 0)];
  endfunction

  task automatic wait_pixels(input int n);
    int target;
    target = pix_count + n;
    while (pix_count < target) @(posedge sys_clk);
  endtask

  // idle until the reader has gone quiet
  task automatic wait_drain();
    int quiet;
    quiet = 0;
    while (quiet < 32) begin
      @(posedge sys_clk);
      quiet = pix_valid ? 0 : quiet + 1;
    end
  endtask

  task automatic set_scan(input logic en);
    @(posedge sys_clk);
    scan_en <= en;
  endtask

  //////////////////////////////
  // test sequence

  initial begin
    logic [`MT_ADDR_W-1:0] adr;
    sys_clk  = 1'b0;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    scan_en  = 1'b0;
    test_num = 0;
    void'($urandom(32'h2ec));
    apply_reset();

    test_num <= 1;
    for (int i = 0; i < N_WORDS; i++) begin
      write_host(`MT_ADDR_W'($urandom_range(`MT_FRAME_BASE - 1, 0)));
    end
    for (int i = 0; i < N_WORDS; i++) begin
      bus_cycle(1'b0, pick_written(), 4'h0, '0);
    end

    test_num <= 2;
    for (int i = 0; i < N_BYTE; i++) begin
      adr = pick_written();
      bus_cycle(1'b1, adr, `MT_MASK_W'($urandom_range(15, 1)), $urandom());
      bus_cycle(1'b0, adr, 4'h0, '0);
    end

    test_num <= 3;
    for (int k = 0; k < `MT_FRAME_WORDS; k++) begin
      bus_cycle(1'b1, `MT_ADDR_W'(`MT_FRAME_BASE + k), 4'hf, $urandom());
    end
    adr = `MT_ADDR_W'(`MT_FRAME_BASE + `MT_FRAME_WORDS - 1);
    bus_cycle(1'b0, adr, 4'h0, '0);  // fill has landed
    set_scan(1'b1);
    wait_pixels(FRAMES * `MT_FRAME_WORDS);

    test_num <= 4;   // scan keeps running
    for (int i = 0; i < N_MIXED; i++) begin
      if ($urandom_range(1, 0) == 1) begin
        write_host(`MT_ADDR_W'($urandom_range(`MT_FRAME_BASE - 1, 0)));
      end else begin
        bus_cycle(1'b0, pick_written(), 4'h0, '0);
      end
    end
    wait_pixels(`MT_FRAME_WORDS);
    set_scan(1'b0);
    wait_drain();

    test_num <= 5;
    set_scan(1'b1);
    wait_pixels(20);                     // reset lands mid frame
    apply_reset();                       // scan_en stays high through it
    wait_pixels(`MT_FRAME_WORDS + 20);   // stop mid frame
    set_scan(1'b0);
    wait_drain();
    set_scan(1'b1);
    wait_pixels(`MT_FRAME_WORDS);
    set_scan(1'b0);
    wait_drain();

    $display("closing: %0d errors, %0d pixels checked", errors, pix_count);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge sys_clk);
    $display("timeout: run did not finish within %0d cycles (test %0d)",
             TIMEOUT_CYCLES, test_num);
    $display("closing: %0d errors, %0d pixels checked", errors, pix_count);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* flist.f */
+incdir+src
src/memtest_pkg.sv
src/mem_port_if.sv
src/port_fifo.sv
src/mem_port_ctrl.sv
src/wb_port_bridge.sv
src/frame_scan_reader.sv
src/memtest_top.sv
test/memtest_checker.sv
test/tb_memtest.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_memtest, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_memtest -Mdir obj_dir -o tb_memtest
	./obj_dir/tb_memtest > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
